//--- all.f
+incdir+verif
design/ctrl_pkg.sv
design/isa_pkg.sv
design/dec_if.sv
design/field_decode.sv
design/reg_select.sv
design/ctrl_assemble.sv
design/ucode_decoder_top.sv
verif/tb_ucode_decoder.sv

//--- design/ctrl_assemble.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_assemble #(
    parameter int queue_depth = 4,
    parameter int out_credits = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    dec_if.dst                           dec,
    input  logic [isa_pkg::num_regs-1:0] rd_sel,
    input  logic [isa_pkg::num_regs-1:0] wr_sel,
    output logic                         out_valid,
    output ctrl_pkg::ctrl_word_t         out_ctrl,
    input  logic                         out_credit,
    output logic                         in_credit
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);
    localparam int crd_w = $clog2(out_credits + 1);

    dec_instr_t       d;
    logic             ex0;
    logic             addr_phase;
    logic             shift_ex;
    alu_ctrl_t        alu_nxt;
    alu_ctrl_t        alu_q;
    shift_ctrl_t      sft_nxt;
    shift_ctrl_t      sft_q;
    logic             s2_valid;
    ctrl_word_t       word;
    ctrl_word_t       mem [queue_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] q_count;
    logic [crd_w-1:0] crd_count;
    logic             push;
    logic             pop;

    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(queue_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign d          = dec.instr;
    assign ex0        = (d.phase == EX0);
    assign addr_phase = !dec.flush_unused && !ex0;
    assign shift_ex   = ex0 && d.shift_op;

    always_comb begin
        alu_nxt.invert_b = (ex0 && d.sub_group) ||
                           (d.phase == FF0 && d.src_mode == AUTO_DEC);
        alu_nxt.arith    = addr_phase || (ex0 && d.arith_op);
        alu_nxt.or_sel   = ex0 && d.is_or;
        // SBC borrows when C is clear, ADC carries when C is set
        alu_nxt.carry_in = (d.phase inside {IF1, FF1, TF1}) ||
                           (ex0 && d.is_adc && d.carry_flag) ||
                           (ex0 && d.sub_group && !(d.is_sbc && d.carry_flag));
        alu_nxt.xor_sel  = alu_nxt.arith || (ex0 && d.is_xor);
    end

    always_comb begin
        sft_nxt.enable = shift_ex;
        sft_nxt.a      = shift_ex && d.shift_code == 3'(ASR);
        sft_nxt.b      = shift_ex && d.shift_code == 3'(ROL);
        sft_nxt.c      = shift_ex && d.shift_code inside {3'(LSR), 3'(ROL), 3'(RLC)};
        sft_nxt.d      = shift_ex && d.shift_code == 3'(ROR);
        sft_nxt.e      = shift_ex && d.shift_code inside {3'(RLC), 3'(RRC)};
        sft_nxt.right  = shift_ex && d.shift_code inside {3'(ASR), 3'(ROR), 3'(RRC)};
        sft_nxt.left   = shift_ex &&
                         d.shift_code inside {3'(ASR), 3'(LSR), 3'(ROL), 3'(RLC)};
    end

    // second stage, lines up with the reg_select outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            alu_q <= alu_nxt;
            sft_q <= sft_nxt;
        end
    end

    always_comb begin
        word.reg_rd = rd_sel;
        word.reg_wr = wr_sel;
        word.alu    = alu_q;
        word.shift  = sft_q;
    end

    // input credits reserve the slot
    assign push      = s2_valid;
    assign out_valid = (q_count != '0) && (crd_count != '0);
    assign pop       = out_valid;
    assign out_ctrl  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            crd_count <= crd_w'(out_credits);
            in_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   q_count <= q_count + cnt_w'(1);
                2'b01:   q_count <= q_count - cnt_w'(1);
                default: q_count <= q_count;
            endcase
            case ({out_credit, pop})
                2'b10:   crd_count <= crd_count + crd_w'(1);
                2'b01:   crd_count <= crd_count - crd_w'(1);
                default: crd_count <= crd_count;
            endcase
            // slot freed, hand one credit back upstream
            in_credit <= pop;
        end
    end

endmodule

`default_nettype wire

//--- design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // machine phase, one state per microcycle
    typedef enum logic [3:0] {
        IF0 = 4'd0,
        IF1 = 4'd1,
        FF0 = 4'd2,
        FF1 = 4'd3,
        FF2 = 4'd4,
        TF0 = 4'd5,
        TF1 = 4'd6,
        EX0 = 4'd7,
        EX1 = 4'd8
    } phase_t;

    typedef struct packed {
        logic invert_b;
        logic arith;
        logic or_sel;
        logic carry_in;
        logic xor_sel;
    } alu_ctrl_t;

    typedef struct packed {
        logic enable;
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic right;
        logic left;
    } shift_ctrl_t;

    // one entry of the output queue
    typedef struct packed {
        logic [7:0]  reg_rd;
        logic [7:0]  reg_wr;
        alu_ctrl_t   alu;
        shift_ctrl_t shift;
    } ctrl_word_t;

endpackage

`default_nettype wire

//--- design/dec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dec_if;

    import isa_pkg::*;

    logic       valid;
    dec_instr_t instr;
    // phase code outside the nine legal states
    logic       flush_unused;

    modport src (
        output valid,
        output instr,
        output flush_unused
    );

    modport dst (
        input valid,
        input instr,
        input flush_unused
    );

endinterface

`default_nettype wire

//--- design/field_decode.sv
`timescale 1ns/1ps
`default_nettype none

module field_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic [isa_pkg::isr_w-1:0] isr,
    input  ctrl_pkg::phase_t          phase,
    input  logic                      psw_n,
    input  logic                      psw_z,
    input  logic                      psw_v,
    input  logic                      psw_c,
    dec_if.src                        dec
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    isr_fields_t f;
    dec_instr_t  nxt;
    logic        br_group;
    logic        flag_sel;

    assign f = isr_fields_t'(isr);

    assign br_group = f.op inside {BRN, BRZ, BRV, BRC, RBN, RBZ, RBV, RBC};

    // low two opcode bits pick N, Z, V or C
    always_comb begin
        case (f.op[1:0])
            2'b00:   flag_sel = psw_n;
            2'b01:   flag_sel = psw_z;
            2'b10:   flag_sel = psw_v;
            default: flag_sel = psw_c;
        endcase
    end

    always_comb begin
        nxt = '0;
        nxt.phase      = phase;
        nxt.wb_op      = f.op inside {CLR, ASL, ASR, RLC, RRC, LSL, LSR, ROL, ROR,
                                      MOV, ADD, ADC, RJP, SUB, SBC, OR, XOR, AND};
        nxt.addr_jump  = f.op inside {JMP, RET, RIT};
        nxt.ret_op     = f.op inside {RET, RIT};
        nxt.jsr_group  = f.op inside {JSR, RJS, SVC};
        nxt.rjs_op     = (f.op == RJS);
        nxt.arith_op   = br_group || f.op inside {MOV, JMP, RET, RIT, ADD, ADC, RJP,
                                                  SUB, SBC, CMP, JSR, RJS, SVC};
        nxt.is_adc     = (f.op == ADC);
        nxt.is_sbc     = (f.op == SBC);
        nxt.sub_group  = f.op inside {SUB, SBC, CMP};
        nxt.is_or      = (f.op == OR);
        nxt.is_xor     = (f.op == XOR);
        // all eight shifts live in 001xxx
        nxt.shift_op   = (f.op[5:3] == 3'b001);
        nxt.shift_code = f.op[2:0];
        nxt.branch_taken = br_group && flag_sel;
        nxt.src_mode   = f.src_mode;
        nxt.src_reg    = f.src_reg;
        nxt.dst_mode   = f.dst_mode;
        nxt.dst_reg    = f.dst_reg;
        nxt.carry_flag = psw_c;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid        <= 1'b0;
            dec.flush_unused <= 1'b0;
        end else begin
            dec.valid        <= in_valid;
            dec.flush_unused <= in_valid && (phase > EX1);
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec.instr <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int isr_w    = 16;
    localparam int op_w     = 6;
    localparam int mode_w   = 2;
    localparam int reg_w    = 3;
    localparam int num_regs = 8;

    typedef enum logic [op_w-1:0] {
        HLT = 6'b000000,
        CLR = 6'b000100,
        ASL = 6'b001000,
        ASR = 6'b001001,
        RLC = 6'b001010,
        RRC = 6'b001011,
        LSL = 6'b001100,
        LSR = 6'b001101,
        ROL = 6'b001110,
        ROR = 6'b001111,
        MOV = 6'b010000,
        JMP = 6'b010001,
        RET = 6'b010010,
        RIT = 6'b010011,
        ADD = 6'b010100,
        RJP = 6'b010101,
        ADC = 6'b010110,
        SUB = 6'b011000,
        SBC = 6'b011010,
        CMP = 6'b011011,
        OR  = 6'b100000,
        XOR = 6'b100001,
        AND = 6'b100010,
        BIT = 6'b100011,
        JSR = 6'b101100,
        RJS = 6'b101101,
        SVC = 6'b101110,
        BRN = 6'b110000,
        BRZ = 6'b110001,
        BRV = 6'b110010,
        BRC = 6'b110011,
        RBN = 6'b111000,
        RBZ = 6'b111001,
        RBV = 6'b111010,
        RBC = 6'b111011
    } opcode_t;

    typedef enum logic [mode_w-1:0] {
        DIRECT   = 2'b00,
        INDIRECT = 2'b01,
        AUTO_DEC = 2'b10,
        AUTO_INC = 2'b11
    } addr_mode_t;

    typedef logic [reg_w-1:0] reg_idx_t;

    // raw layout of the instruction-state word, msb first
    typedef struct packed {
        opcode_t    op;
        addr_mode_t src_mode;
        reg_idx_t   src_reg;
        addr_mode_t dst_mode;
        reg_idx_t   dst_reg;
    } isr_fields_t;

    typedef struct packed {
        ctrl_pkg::phase_t phase;
        logic             wb_op;
        logic             addr_jump;
        logic             ret_op;
        logic             jsr_group;
        logic             rjs_op;
        logic             arith_op;
        logic             is_adc;
        logic             is_sbc;
        logic             sub_group;
        logic             is_or;
        logic             is_xor;
        logic             shift_op;
        // low opcode bits pick the shift flavour
        logic [2:0]       shift_code;
        logic             branch_taken;
        addr_mode_t       src_mode;
        reg_idx_t         src_reg;
        addr_mode_t       dst_mode;
        reg_idx_t         dst_reg;
        logic             carry_flag;
    } dec_instr_t;

endpackage

`default_nettype wire

//--- design/reg_select.sv
`timescale 1ns/1ps
`default_nettype none

module reg_select #(
    parameter int reg_index = 0
) (
    input  logic clk,
    input  logic rst,
    dec_if.dst   dec,
    output logic rd,
    output logic wr
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam reg_idx_t own   = reg_idx_t'(reg_index);
    localparam bit       is_sp = (reg_index == 6);
    localparam bit       is_pc = (reg_index == 7);

    dec_instr_t d;
    logic       src_hit;
    logic       dst_hit;
    logic       rd_nxt;
    logic       wr_nxt;

    assign d       = dec.instr;
    assign src_hit = (d.src_reg == own);
    assign dst_hit = (d.dst_reg == own);

    always_comb begin
        rd_nxt = (d.phase == FF0 && src_hit) ||
                 (d.phase == FF1 && d.src_mode == AUTO_INC && src_hit) ||
                 (d.phase == TF0 && dst_hit) ||
                 (d.phase == TF1 && d.dst_mode == AUTO_INC && dst_hit);
        // stack pointer is read on return
        if (is_sp) begin
            rd_nxt = rd_nxt || (d.phase == EX0 && d.ret_op);
        end
        if (is_pc) begin
            rd_nxt = rd_nxt || d.phase == IF0 || d.phase == IF1 ||
                     (d.phase == EX1 && d.rjs_op);
        end

        wr_nxt = (d.phase == FF0 && src_hit) ||
                 (d.phase == FF1 && d.src_mode == AUTO_INC && src_hit) ||
                 (d.phase == TF1 && d.dst_mode == AUTO_INC && dst_hit) ||
                 (d.phase == EX0 && d.wb_op && d.dst_mode == DIRECT && dst_hit);
        // pc update: fetch increment, jumps, taken branches, calls
        if (is_pc) begin
            wr_nxt = wr_nxt || d.phase == IF1 ||
                     (d.phase == EX0 && (d.addr_jump || d.branch_taken)) ||
                     (d.phase == EX1 && d.jsr_group);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd <= 1'b0;
            wr <= 1'b0;
        end else begin
            rd <= dec.valid && rd_nxt;
            wr <= dec.valid && wr_nxt;
        end
    end

endmodule

`default_nettype wire

//--- design/ucode_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module ucode_decoder_top #(
    parameter int queue_depth = 4,
    parameter int out_credits = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic [isa_pkg::isr_w-1:0] isr,
    input  ctrl_pkg::phase_t          phase,
    input  logic                      psw_n,
    input  logic                      psw_z,
    input  logic                      psw_v,
    input  logic                      psw_c,
    output logic                      in_credit,
    output logic                      out_valid,
    output ctrl_pkg::ctrl_word_t      out_ctrl,
    input  logic                      out_credit
);

    import isa_pkg::*;

    dec_if dec ();

    logic [num_regs-1:0] rd_sel;
    logic [num_regs-1:0] wr_sel;

    field_decode u_field_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .isr      (isr),
        .phase    (phase),
        .psw_n    (psw_n),
        .psw_z    (psw_z),
        .psw_v    (psw_v),
        .psw_c    (psw_c),
        .dec      (dec.src)
    );

    // one select slice per register
    for (genvar i = 0; i < num_regs; i++) begin : g_reg
        reg_select #(
            .reg_index (i)
        ) u_reg_select (
            .clk (clk),
            .rst (rst),
            .dec (dec.dst),
            .rd  (rd_sel[i]),
            .wr  (wr_sel[i])
        );
    end

    ctrl_assemble #(
        .queue_depth (queue_depth),
        .out_credits (out_credits)
    ) u_ctrl_assemble (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec.dst),
        .rd_sel     (rd_sel),
        .wr_sel     (wr_sel),
        .out_valid  (out_valid),
        .out_ctrl   (out_ctrl),
        .out_credit (out_credit),
        .in_credit  (in_credit)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the decoder regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_ucode_decoder -f all.f -o sim_ucode
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ucode 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
    exit 0
fi
exit 1

//--- verif/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// expected control word from isr fields, phase and psw flags (n z v c, msb first)
function automatic ctrl_word_t expected_ctrl(
    input logic [isr_w-1:0] word,
    input phase_t           ph,
    input logic [3:0]       nzvc
);
    ctrl_word_t exp_w;
    logic [5:0] op;
    logic [1:0] sm;
    logic [2:0] sr;
    logic [1:0] dm;
    logic [2:0] dr;
    logic       flag;
    logic       br;
    logic       taken;
    logic       wb;
    logic       ex0;
    logic       addr_ph;
    logic       sh;
    logic       rd;
    logic       wr;

    op = word[15:10];
    sm = word[9:8];
    sr = word[7:5];
    dm = word[4:3];
    dr = word[2:0];

    case (op[1:0])
        2'b00:   flag = nzvc[3];
        2'b01:   flag = nzvc[2];
        2'b10:   flag = nzvc[1];
        default: flag = nzvc[0];
    endcase
    br    = (op[5:2] == 4'b1100) || (op[5:2] == 4'b1110);
    taken = br && flag;
    wb    = op inside {CLR, ASL, ASR, RLC, RRC, LSL, LSR, ROL, ROR,
                       MOV, ADD, ADC, RJP, SUB, SBC, OR, XOR, AND};
    ex0   = (ph == EX0);
    // address phases only, codes past EX1 are not one of them
    addr_ph = ph inside {IF0, IF1, FF0, FF1, FF2, TF0, TF1, EX1};
    exp_w = '0;

    for (int r = 0; r < num_regs; r++) begin
        rd = (ph == FF0 && sr == 3'(r)) ||
             (ph == FF1 && sm == AUTO_INC && sr == 3'(r)) ||
             (ph == TF0 && dr == 3'(r)) ||
             (ph == TF1 && dm == AUTO_INC && dr == 3'(r));
        wr = (ph == FF0 && sr == 3'(r)) ||
             (ph == FF1 && sm == AUTO_INC && sr == 3'(r)) ||
             (ph == TF1 && dm == AUTO_INC && dr == 3'(r)) ||
             (ex0 && wb && dm == DIRECT && dr == 3'(r));
        if (r == 6) begin
            rd = rd || (ex0 && op inside {RET, RIT});
        end
        // program counter
        if (r == 7) begin
            rd = rd || ph == IF0 || ph == IF1 || (ph == EX1 && op == RJS);
            wr = wr || ph == IF1 || (ex0 && (op inside {JMP, RET, RIT} || taken)) ||
                 (ph == EX1 && op inside {JSR, RJS, SVC});
        end
        exp_w.reg_rd[r] = rd;
        exp_w.reg_wr[r] = wr;
    end

    exp_w.alu.invert_b = (ex0 && op inside {SUB, SBC, CMP}) || (ph == FF0 && sm == AUTO_DEC);
    exp_w.alu.arith    = addr_ph ||
                         (ex0 && (br || op inside {MOV, JMP, RET, RIT, ADD, ADC, RJP,
                                                   SUB, SBC, CMP, JSR, RJS, SVC}));
    exp_w.alu.or_sel   = ex0 && op == OR;
    exp_w.alu.carry_in = ph == IF1 || ph == FF1 || ph == TF1 ||
                         (ex0 && ((op == ADC && nzvc[0]) || op == SUB ||
                                  (op == SBC && !nzvc[0]) || op == CMP));
    exp_w.alu.xor_sel  = exp_w.alu.arith || (ex0 && op == XOR);

    sh = ex0 && op[5:3] == 3'b001;
    exp_w.shift.enable = sh;
    exp_w.shift.a      = sh && op == ASR;
    exp_w.shift.b      = sh && op == ROL;
    exp_w.shift.c      = sh && op inside {LSR, ROL, RLC};
    exp_w.shift.d      = sh && op == ROR;
    exp_w.shift.e      = sh && op inside {RLC, RRC};
    exp_w.shift.right  = sh && op inside {ASR, ROR, RRC};
    exp_w.shift.left   = sh && op inside {ASR, LSR, ROL, RLC};
    return exp_w;
endfunction

`endif

//--- verif/tb_ucode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ucode_decoder;

    import isa_pkg::*;
    import ctrl_pkg::*;

    `include "tb_ref_model.svh"

    localparam int clk_period   = 8;
    localparam int queue_depth  = 4;
    localparam int out_credits  = 2;
    localparam int bp_words     = 100;
    localparam int total_words  = 224 + 140 + 132 + 400 + bp_words;
    // about 12 cycles per word, plus the long credit stalls
    localparam int limit_cycles = 12 * total_words + 48 * bp_words + 1000;

    localparam logic [5:0] kept_ops [35] = '{
        HLT, CLR, ASL, ASR, RLC, RRC, LSL, LSR, ROL, ROR, MOV, JMP, RET, RIT,
        ADD, RJP, ADC, SUB, SBC, CMP, OR, XOR, AND, BIT, JSR, RJS, SVC,
        BRN, BRZ, BRV, BRC, RBN, RBZ, RBV, RBC
    };
    localparam logic [5:0] br_ops [8] = '{BRN, BRZ, BRV, BRC, RBN, RBZ, RBV, RBC};

    logic             clk        = 1'b0;
    logic             rst        = 1'b1;
    logic             in_valid   = 1'b0;
    logic [isr_w-1:0] isr        = '0;
    phase_t           phase      = IF0;
    logic             psw_n      = 1'b0;
    logic             psw_z      = 1'b0;
    logic             psw_v      = 1'b0;
    logic             psw_c      = 1'b0;
    logic             out_credit = 1'b0;
    logic             in_credit;
    logic             out_valid;
    ctrl_word_t       out_ctrl;

    integer     seed     = 32'ha1aa;
    ctrl_word_t exp_q[$];
    int         sent     = 0;
    int         returned = 0;
    int         n_out    = 0;
    logic       bp_on    = 1'b0;
    logic       hold     = 1'b0;
    int         bp_cnt   = 0;
    int         model_crd;
    int         owed;
    logic       last_out_valid;
    ctrl_word_t exp_w;

    ucode_decoder_top #(
        .queue_depth (queue_depth),
        .out_credits (out_credits)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .isr        (isr),
        .phase      (phase),
        .psw_n      (psw_n),
        .psw_z      (psw_z),
        .psw_v      (psw_v),
        .psw_c      (psw_c),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_ctrl   (out_ctrl),
        .out_credit (out_credit)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // waits for a free input credit, then drives one word
    task automatic send_word(input logic [isr_w-1:0] word, input phase_t ph,
                             input logic [3:0] nzvc);
        @(posedge clk);
        while (queue_depth + returned - sent <= 0) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        in_valid <= 1'b1;
        isr      <= word;
        phase    <= ph;
        psw_n    <= nzvc[3];
        psw_z    <= nzvc[2];
        psw_v    <= nzvc[1];
        psw_c    <= nzvc[0];
        exp_q.push_back(expected_ctrl(word, ph, nzvc));
        sent = sent + 1;
    endtask

    task automatic send_random(input int count);
        logic [31:0]      r;
        logic [isr_w-1:0] word;
        phase_t           ph;
        int               idx;
        for (int i = 0; i < count; i++) begin
            r    = $random(seed);
            word = r[15:0];
            ph   = phase_t'(4'($unsigned($random(seed)) % 9));
            // mostly legal opcodes and phases, the rest raw bits
            if (r[17:16] != 2'b00) begin
                idx = int'($unsigned($random(seed)) % 35);
                word[15:10] = kept_ops[idx];
            end else begin
                ph = phase_t'(r[25:22]);
            end
            send_word(word, ph, r[21:18]);
        end
    endtask

    task automatic wait_drained();
        @(posedge clk);
        in_valid <= 1'b0;
        while (n_out != sent) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    // downstream stalls its credits for 40 of every 48 cycles
    always @(posedge clk) begin
        if (bp_on) begin
            bp_cnt = bp_cnt + 1;
            hold  <= (bp_cnt % 48) < 40;
        end else begin
            bp_cnt = 0;
            hold  <= 1'b0;
        end
    end

    // scoreboard and downstream credit return
    always @(posedge clk) begin
        if (rst) begin
            model_crd      = out_credits;
            owed           = 0;
            last_out_valid = 1'b0;
            out_credit    <= 1'b0;
        end else begin
            check_value("in_credit", 32'(in_credit), 32'(last_out_valid));
            if (in_credit) begin
                returned <= returned + 1;
            end
            if (out_valid) begin
                if (model_crd <= 0) begin
                    $display("out_valid raised at %0t with no downstream credit left", $time);
                    abort_run();
                end else if (exp_q.size() == 0) begin
                    $display("out_valid raised at %0t with no word outstanding", $time);
                    abort_run();
                end else begin
                    exp_w = exp_q.pop_front();
                    check_value("out_ctrl.reg_rd", 32'(out_ctrl.reg_rd), 32'(exp_w.reg_rd));
                    check_value("out_ctrl.reg_wr", 32'(out_ctrl.reg_wr), 32'(exp_w.reg_wr));
                    check_value("out_ctrl.alu", 32'(out_ctrl.alu), 32'(exp_w.alu));
                    check_value("out_ctrl.shift", 32'(out_ctrl.shift), 32'(exp_w.shift));
                    model_crd = model_crd - 1;
                    owed      = owed + 1;
                    n_out    <= n_out + 1;
                end
            end
            if (out_credit) begin
                model_crd = model_crd + 1;
            end
            last_out_valid = out_valid;
            if (owed > 0 && !hold) begin
                out_credit <= 1'b1;
                owed = owed - 1;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    initial begin
        #(limit_cycles * clk_period);
        $display("watchdog expired after %0d cycles, run did not finish", limit_cycles);
        abort_run();
    end

    initial begin
        logic [31:0] r;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // quiet outputs until the first word goes in
        repeat (6) begin
            @(posedge clk);
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("in_credit", 32'(in_credit), 32'd0);
        end

        // fetch and operand phases, every register and mode
        for (int p = 0; p < 7; p++) begin
            for (int m = 0; m < 4; m++) begin
                for (int g = 0; g < num_regs; g++) begin
                    send_word({6'(MOV), 2'(m), 3'(g), 2'(m + 1), 3'(7 - g)},
                              phase_t'(4'(p)), 4'b0000);
                end
            end
        end

        // every opcode in both execute phases, direct and indirect destination
        foreach (kept_ops[k]) begin
            for (int j = 0; j < 2; j++) begin
                for (int md = 0; md < 2; md++) begin
                    r = $random(seed);
                    send_word({kept_ops[k], r[4:0], 2'(md), r[7:5]},
                              (j == 0) ? EX0 : EX1, r[11:8]);
                end
            end
        end

        // branches against all flag combinations, then carry-dependent ops
        foreach (br_ops[b]) begin
            for (int f = 0; f < 16; f++) begin
                r = $random(seed);
                send_word({br_ops[b], r[9:0]}, EX0, 4'(f));
            end
        end
        for (int c = 0; c < 2; c++) begin
            r = $random(seed);
            send_word({6'(ADC), r[9:0]}, EX0, {3'b000, 1'(c)});
            send_word({6'(SBC), r[9:0]}, EX0, {3'b000, 1'(c)});
        end

        send_random(400);
        wait_drained();

        bp_on <= 1'b1;
        send_random(bp_words);
        wait_drained();
        bp_on <= 1'b0;
        repeat (4) @(posedge clk);

        if (returned == n_out) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("credit count mismatch at end: delivered %0d, credits back %0d",
                     n_out, returned);
            abort_run();
        end
    end

endmodule

`default_nettype wire
